// File: l2_map_pkg.sv
// L2 memory map definitions
// Scratchpad depth, data widths and the offsets of the LLC configuration
// registers, plus the value returned for an unmapped register read

package l2_map_pkg;

  // Default scratchpad depth in 32-bit words
  localparam int unsigned L2_NUM_WORDS = 1024;

  // Byte address into the L2
  typedef logic [31:0] l2_addr_t;

  typedef logic [31:0] l2_data_t;

  typedef logic [31:0] cfg_data_t;

  // Word offset into the configuration space
  typedef logic [7:0] cfg_offset_t;

  // Configuration register offsets
  localparam cfg_offset_t CFG_CACHE_START = 8'd0;
  localparam cfg_offset_t CFG_CACHE_END   = 8'd1;
  localparam cfg_offset_t CFG_READ_HITS   = 8'd2;
  localparam cfg_offset_t CFG_WRITE_HITS  = 8'd3;

  // Read value of an unmapped offset
  localparam cfg_data_t CFG_ERR_DATA = 32'hdeadf000;

endpackage

// File: host_bus_pkg.sv
// Host domain bus types
// Request and response structs of the L2 ports, the owner tag that
// travels with each access, and the configuration request

package host_bus_pkg;

  import l2_map_pkg::*;

  // Peer that issued an access
  typedef enum logic {
    OWNER_HOST = 1'b0,
    OWNER_UDMA = 1'b1
  } owner_e;

  typedef struct packed {
    l2_addr_t   addr;
    logic       we;
    logic [3:0] be;
    l2_data_t   wdata;
  } l2_req_t;

  typedef struct packed {
    l2_data_t rdata;
  } l2_rsp_t;

  // Request as seen by the memory, tagged with its owner
  typedef struct packed {
    l2_req_t req;
    owner_e  owner;
  } mem_req_t;

  typedef struct packed {
    l2_rsp_t rsp;
    owner_e  owner;
  } mem_rsp_t;

  typedef struct packed {
    cfg_offset_t offset;
    logic        we;
    cfg_data_t   wdata;
  } cfg_req_t;

endpackage

// File: l2_rr_arbiter.sv
`timescale 1ns/100ps
// Round-robin arbiter for the shared L2
// Grants the host or the uDMA port one access per cycle, alternating on a
// tie, and tags the access with its owner. Responses come back with the tag
// and are steered to the matching port.

module l2_rr_arbiter
  import host_bus_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  l2_req_t  host_req_i,
  input  logic     host_req_valid_i,
  output logic     host_req_ready_o,
  output l2_rsp_t  host_rsp_o,
  output logic     host_rsp_valid_o,
  input  l2_req_t  udma_req_i,
  input  logic     udma_req_valid_i,
  output logic     udma_req_ready_o,
  output l2_rsp_t  udma_rsp_o,
  output logic     udma_rsp_valid_o,
  output mem_req_t mem_req_o,
  output logic     mem_req_valid_o,
  input  mem_rsp_t mem_rsp_i,
  input  logic     mem_rsp_valid_i
);

  owner_e last_q;
  logic   grant_host;
  logic   grant_udma;

  // A peer loses only when the other is valid and it was granted last
  assign host_req_ready_o = !udma_req_valid_i || (last_q == OWNER_UDMA);
  assign udma_req_ready_o = !host_req_valid_i || (last_q == OWNER_HOST);

  assign grant_host = host_req_valid_i && host_req_ready_o;
  assign grant_udma = udma_req_valid_i && udma_req_ready_o;

  assign mem_req_valid_o = grant_host || grant_udma;
  assign mem_req_o.req   = grant_host ? host_req_i : udma_req_i;
  assign mem_req_o.owner = grant_host ? OWNER_HOST : OWNER_UDMA;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_q <= OWNER_UDMA;
    end else if (mem_req_valid_o) begin
      last_q <= mem_req_o.owner;
    end
  end

  // Response steering by owner tag
  assign host_rsp_o       = mem_rsp_i.rsp;
  assign udma_rsp_o       = mem_rsp_i.rsp;
  assign host_rsp_valid_o = mem_rsp_valid_i && (mem_rsp_i.owner == OWNER_HOST);
  assign udma_rsp_valid_o = mem_rsp_valid_i && (mem_rsp_i.owner == OWNER_UDMA);

endmodule

// File: l2_mem.sv
`timescale 1ns/100ps
// L2 scratchpad memory
// Single-port word array with byte enables. Every request gets a response
// one cycle later; writes return zero data.

module l2_mem
  import l2_map_pkg::*;
  import host_bus_pkg::*;
#(
  parameter int unsigned NumWords = L2_NUM_WORDS
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  mem_req_t mem_req_i,
  input  logic     mem_req_valid_i,
  output mem_rsp_t mem_rsp_o,
  output logic     mem_rsp_valid_o
);

  localparam int unsigned AddrBits = $clog2(NumWords);

  l2_data_t              mem_q [NumWords];
  logic [AddrBits-1:0]   word_idx;
  mem_rsp_t              rsp_q;
  logic                  rsp_valid_q;

  // Byte address to word index, wrapping at the array size
  assign word_idx = mem_req_i.req.addr[AddrBits+1:2];

  always_ff @(posedge clk_i) begin
    if (mem_req_valid_i && mem_req_i.req.we) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_req_i.req.be[b]) begin
          mem_q[word_idx][8*b +: 8] <= mem_req_i.req.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_req_valid_i) begin
      rsp_q.rsp.rdata <= mem_req_i.req.we ? '0 : mem_q[word_idx];
      rsp_q.owner     <= mem_req_i.owner;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= mem_req_valid_i;
    end
  end

  assign mem_rsp_o       = rsp_q;
  assign mem_rsp_valid_o = rsp_valid_q;

endmodule

// File: llc_cfg_regs.sv
`timescale 1ns/100ps
// LLC configuration registers
// Holds the cached address window and counts host reads and writes that
// land inside it. Registers are reached through a valid/ready port with
// one outstanding response.

module llc_cfg_regs
  import l2_map_pkg::*;
  import host_bus_pkg::*;
#(
  parameter int unsigned NumWords = L2_NUM_WORDS
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  cfg_req_t  cfg_req_i,
  input  logic      cfg_req_valid_i,
  output logic      cfg_req_ready_o,
  output cfg_data_t cfg_rsp_o,
  output logic      cfg_rsp_valid_o,
  input  logic      cfg_rsp_ready_i,
  input  mem_req_t  mem_req_i,
  input  logic      mem_req_valid_i
);

  // Window end cannot pass the top of the L2
  localparam cfg_data_t EndMax = cfg_data_t'(NumWords * 4);

  cfg_data_t cache_start_q;
  cfg_data_t cache_end_q;
  cfg_data_t read_hits_q;
  cfg_data_t write_hits_q;
  cfg_data_t rsp_data_q;
  logic      rsp_valid_q;
  cfg_data_t rdata;
  logic      cfg_accept;
  logic      in_window;
  logic      read_hit;
  logic      write_hit;

  assign cfg_req_ready_o = !rsp_valid_q;
  assign cfg_accept      = cfg_req_valid_i && cfg_req_ready_o;

  always_comb begin
    case (cfg_req_i.offset)
      CFG_CACHE_START: rdata = cache_start_q;
      CFG_CACHE_END:   rdata = cache_end_q;
      CFG_READ_HITS:   rdata = read_hits_q;
      CFG_WRITE_HITS:  rdata = write_hits_q;
      default:         rdata = CFG_ERR_DATA;
    endcase
  end

  // Only host traffic counts
  assign in_window = mem_req_valid_i && (mem_req_i.owner == OWNER_HOST) &&
                     (mem_req_i.req.addr >= cache_start_q) &&
                     (mem_req_i.req.addr < cache_end_q);
  assign read_hit  = in_window && !mem_req_i.req.we;
  assign write_hit = in_window && mem_req_i.req.we;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cache_start_q <= '0;
      cache_end_q   <= '0;
      read_hits_q   <= '0;
      write_hits_q  <= '0;
    end else begin
      if (cfg_accept && cfg_req_i.we && (cfg_req_i.offset == CFG_CACHE_START)) begin
        cache_start_q <= cfg_req_i.wdata;
      end
      if (cfg_accept && cfg_req_i.we && (cfg_req_i.offset == CFG_CACHE_END)) begin
        cache_end_q <= (cfg_req_i.wdata > EndMax) ? EndMax : cfg_req_i.wdata;
      end
      // Clear beats a hit in the same cycle
      if (cfg_accept && cfg_req_i.we && (cfg_req_i.offset == CFG_READ_HITS)) begin
        read_hits_q <= '0;
      end else if (read_hit && (read_hits_q != '1)) begin
        read_hits_q <= read_hits_q + 32'd1;
      end
      if (cfg_accept && cfg_req_i.we && (cfg_req_i.offset == CFG_WRITE_HITS)) begin
        write_hits_q <= '0;
      end else if (write_hit && (write_hits_q != '1)) begin
        write_hits_q <= write_hits_q + 32'd1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (cfg_accept) begin
      rsp_valid_q <= 1'b1;
    end else if (cfg_rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cfg_accept) begin
      rsp_data_q <= cfg_req_i.we ? '0 : rdata;
    end
  end

  assign cfg_rsp_o       = rsp_data_q;
  assign cfg_rsp_valid_o = rsp_valid_q;

endmodule

// File: dma_evt_sync.sv
`timescale 1ns/100ps
// Receiver for the cluster DMA event
// The event arrives as a toggling level. Two flops synchronize it and a
// third detects each change, giving a one-cycle pulse per event.

module dma_evt_sync (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic evt_toggle_i,
  output logic evt_pulse_o,
  output logic evt_ack_o
);

  logic sync1_q;
  logic sync2_q;
  logic edge_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync1_q <= 1'b0;
      sync2_q <= 1'b0;
      edge_q  <= 1'b0;
    end else begin
      sync1_q <= evt_toggle_i;
      sync2_q <= sync1_q;
      edge_q  <= sync2_q;
    end
  end

  assign evt_pulse_o = sync2_q ^ edge_q;
  // Acknowledge returns the synchronized level to the sender
  assign evt_ack_o   = sync2_q;

endmodule

// File: host_domain.sv
`timescale 1ns/100ps
// Host domain memory side
// Host and uDMA ports share the L2 scratchpad through a round-robin
// arbiter. The LLC configuration block watches host traffic for window
// hits, and the cluster DMA event is synchronized and acknowledged.

module host_domain
  import l2_map_pkg::*;
  import host_bus_pkg::*;
#(
  parameter int unsigned NumWords = L2_NUM_WORDS
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  l2_req_t   host_req_i,
  input  logic      host_req_valid_i,
  output logic      host_req_ready_o,
  output l2_rsp_t   host_rsp_o,
  output logic      host_rsp_valid_o,
  input  l2_req_t   udma_req_i,
  input  logic      udma_req_valid_i,
  output logic      udma_req_ready_o,
  output l2_rsp_t   udma_rsp_o,
  output logic      udma_rsp_valid_o,
  input  cfg_req_t  cfg_req_i,
  input  logic      cfg_req_valid_i,
  output logic      cfg_req_ready_o,
  output cfg_data_t cfg_rsp_o,
  output logic      cfg_rsp_valid_o,
  input  logic      cfg_rsp_ready_i,
  input  logic      dma_pe_evt_valid_i,
  output logic      dma_pe_evt_o,
  output logic      dma_pe_evt_ack_o
);

  mem_req_t mem_req;
  logic     mem_req_valid;
  mem_rsp_t mem_rsp;
  logic     mem_rsp_valid;

  l2_rr_arbiter i_l2_rr_arbiter (
    .clk_i            ( clk_i            ),
    .arst_n_i         ( arst_n_i         ),
    .host_req_i       ( host_req_i       ),
    .host_req_valid_i ( host_req_valid_i ),
    .host_req_ready_o ( host_req_ready_o ),
    .host_rsp_o       ( host_rsp_o       ),
    .host_rsp_valid_o ( host_rsp_valid_o ),
    .udma_req_i       ( udma_req_i       ),
    .udma_req_valid_i ( udma_req_valid_i ),
    .udma_req_ready_o ( udma_req_ready_o ),
    .udma_rsp_o       ( udma_rsp_o       ),
    .udma_rsp_valid_o ( udma_rsp_valid_o ),
    .mem_req_o        ( mem_req          ),
    .mem_req_valid_o  ( mem_req_valid    ),
    .mem_rsp_i        ( mem_rsp          ),
    .mem_rsp_valid_i  ( mem_rsp_valid    )
  );

  l2_mem #(
    .NumWords ( NumWords )
  ) i_l2_mem (
    .clk_i           ( clk_i         ),
    .arst_n_i        ( arst_n_i      ),
    .mem_req_i       ( mem_req       ),
    .mem_req_valid_i ( mem_req_valid ),
    .mem_rsp_o       ( mem_rsp       ),
    .mem_rsp_valid_o ( mem_rsp_valid )
  );

  llc_cfg_regs #(
    .NumWords ( NumWords )
  ) i_llc_cfg_regs (
    .clk_i           ( clk_i           ),
    .arst_n_i        ( arst_n_i        ),
    .cfg_req_i       ( cfg_req_i       ),
    .cfg_req_valid_i ( cfg_req_valid_i ),
    .cfg_req_ready_o ( cfg_req_ready_o ),
    .cfg_rsp_o       ( cfg_rsp_o       ),
    .cfg_rsp_valid_o ( cfg_rsp_valid_o ),
    .cfg_rsp_ready_i ( cfg_rsp_ready_i ),
    .mem_req_i       ( mem_req         ),
    .mem_req_valid_i ( mem_req_valid   )
  );

  dma_evt_sync i_dma_evt_sync (
    .clk_i        ( clk_i              ),
    .arst_n_i     ( arst_n_i           ),
    .evt_toggle_i ( dma_pe_evt_valid_i ),
    .evt_pulse_o  ( dma_pe_evt_o       ),
    .evt_ack_o    ( dma_pe_evt_ack_o   )
  );

endmodule

// File: tb_host_domain.sv
`timescale 1ns/100ps
// Testbench for the host domain memory side
// Replays operations from a stimulus file against the L2 ports, the LLC
// configuration port and the DMA event input, and checks every response

module tb_host_domain
  import l2_map_pkg::*;
  import host_bus_pkg::*;
();

  localparam int MaxOps = 64;

  logic      clk;
  logic      arst_n;
  l2_req_t   host_req;
  logic      host_req_valid;
  logic      host_req_ready;
  l2_rsp_t   host_rsp;
  logic      host_rsp_valid;
  l2_req_t   udma_req;
  logic      udma_req_valid;
  logic      udma_req_ready;
  l2_rsp_t   udma_rsp;
  logic      udma_rsp_valid;
  cfg_req_t  cfg_req;
  logic      cfg_req_valid;
  logic      cfg_req_ready;
  cfg_data_t cfg_rsp;
  logic      cfg_rsp_valid;
  logic      cfg_rsp_ready;
  logic      evt_in;
  logic      evt_pulse;
  logic      evt_ack;

  int        tnum [MaxOps];
  string     opc [MaxOps];
  l2_addr_t  acol [MaxOps];
  l2_data_t  dcol [MaxOps];
  l2_data_t  ecol [MaxOps];
  int        n_ops;
  int        test_errs;
  int        pass_cnt;
  int        fail_cnt;
  int        cycles;
  int        cycle_limit = 100000;
  integer    seed = 32'h991909b1;
  // Last granted peer as the arbiter should see it
  owner_e    model_last = OWNER_UDMA;

  host_domain dut0 (
    .clk_i              ( clk            ),
    .arst_n_i           ( arst_n         ),
    .host_req_i         ( host_req       ),
    .host_req_valid_i   ( host_req_valid ),
    .host_req_ready_o   ( host_req_ready ),
    .host_rsp_o         ( host_rsp       ),
    .host_rsp_valid_o   ( host_rsp_valid ),
    .udma_req_i         ( udma_req       ),
    .udma_req_valid_i   ( udma_req_valid ),
    .udma_req_ready_o   ( udma_req_ready ),
    .udma_rsp_o         ( udma_rsp       ),
    .udma_rsp_valid_o   ( udma_rsp_valid ),
    .cfg_req_i          ( cfg_req        ),
    .cfg_req_valid_i    ( cfg_req_valid  ),
    .cfg_req_ready_o    ( cfg_req_ready  ),
    .cfg_rsp_o          ( cfg_rsp        ),
    .cfg_rsp_valid_o    ( cfg_rsp_valid  ),
    .cfg_rsp_ready_i    ( cfg_rsp_ready  ),
    .dma_pe_evt_valid_i ( evt_in         ),
    .dma_pe_evt_o       ( evt_pulse      ),
    .dma_pe_evt_ack_o   ( evt_ack        )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("run stopped after %0d cycles without finishing", cycles);
      $display("tests failed");
      $finish;
    end
  end

  task automatic report_error(input string msg);
    $display("error at %0t: %s", $time, msg);
    test_errs++;
  endtask

  task automatic check_l2(input l2_data_t got, input l2_data_t exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_cfg(input cfg_data_t got, input cfg_data_t exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_evt(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_owner(input owner_e got, input owner_e exp, input string what);
    if (got != exp) begin
      $display("[FAIL] %0t %s: got %s, expected %s", $time, what, got.name(), exp.name());
      test_errs++;
    end
  endtask

  function automatic l2_req_t make_req(input l2_addr_t addr, input logic we,
                                       input logic [3:0] be, input l2_data_t data);
    l2_req_t req;
    req.addr  = addr;
    req.we    = we;
    req.be    = be;
    req.wdata = data;
    return req;
  endfunction

  task automatic load_stim(output bit ok);
    int       fd;
    int       r;
    int       t;
    string    line;
    string    op;
    l2_addr_t a;
    l2_data_t d;
    l2_data_t e;
    n_ops = 0;
    ok    = 1'b0;
    fd    = $fopen("host_domain_stim.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (!$feof(fd)) begin
        r = $fgets(line, fd);
        if (r > 0 && line.len() > 1 && line[0] != "#") begin
          r = $sscanf(line, "%d %s %h %h %h", t, op, a, d, e);
          if (r == 5 && n_ops < MaxOps) begin
            tnum[n_ops] = t;
            opc[n_ops]  = op;
            acol[n_ops] = a;
            dcol[n_ops] = d;
            ecol[n_ops] = e;
            n_ops++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // One L2 access; the response must show up the cycle after acceptance
  task automatic l2_access(input owner_e who, input logic we, input l2_addr_t addr,
                           input l2_data_t data, input logic [3:0] be,
                           output l2_data_t rdata);
    l2_req_t req;
    req = make_req(addr, we, be, data);
    @(posedge clk);
    if (who == OWNER_HOST) begin
      host_req       <= req;
      host_req_valid <= 1'b1;
    end else begin
      udma_req       <= req;
      udma_req_valid <= 1'b1;
    end
    @(negedge clk);
    while (!((who == OWNER_HOST) ? host_req_ready : udma_req_ready)) @(negedge clk);
    @(posedge clk);
    model_last = who;
    host_req_valid <= 1'b0;
    udma_req_valid <= 1'b0;
    @(negedge clk);
    rdata = (who == OWNER_HOST) ? host_rsp.rdata : udma_rsp.rdata;
    if (!((who == OWNER_HOST) ? host_rsp_valid : udma_rsp_valid)) begin
      report_error("L2 response missing one cycle after acceptance");
    end
  endtask

  // Both peers stream n writes at once, then the words are read back through both ports
  task automatic run_tie(input l2_addr_t base, input int n);
    l2_data_t hdata [8];
    l2_data_t udata [8];
    l2_data_t rd;
    int       hi;
    int       ui;
    int       hrsp;
    int       ursp;
    logic     both;
    owner_e   granted;
    owner_e   expect_owner;
    hi = 0;
    ui = 0;
    hrsp = 0;
    ursp = 0;
    granted = OWNER_HOST;
    for (int i = 0; i < n; i++) begin
      hdata[i] = $random(seed);
      udata[i] = $random(seed);
    end
    expect_owner = (model_last == OWNER_HOST) ? OWNER_UDMA : OWNER_HOST;
    while (hi < n || ui < n) begin
      @(posedge clk);
      host_req_valid <= (hi < n);
      udma_req_valid <= (ui < n);
      if (hi < n) host_req <= make_req(base + l2_addr_t'(4 * hi), 1'b1, 4'hf, hdata[hi]);
      if (ui < n) udma_req <= make_req(base + 32'h100 + l2_addr_t'(4 * ui), 1'b1, 4'hf,
                                       udata[ui]);
      @(negedge clk);
      if (host_rsp_valid) hrsp++;
      if (udma_rsp_valid) ursp++;
      both = host_req_valid && udma_req_valid;
      if (host_req_valid && host_req_ready) begin
        granted = OWNER_HOST;
        hi++;
      end else if (udma_req_valid && udma_req_ready) begin
        granted = OWNER_UDMA;
        ui++;
      end else begin
        report_error("no grant while a request was pending");
      end
      if (both) begin
        check_owner(granted, expect_owner, "grant under tie");
        expect_owner = (granted == OWNER_HOST) ? OWNER_UDMA : OWNER_HOST;
      end
      model_last = granted;
    end
    @(posedge clk);
    host_req_valid <= 1'b0;
    udma_req_valid <= 1'b0;
    repeat (2) begin
      @(negedge clk);
      if (host_rsp_valid) hrsp++;
      if (udma_rsp_valid) ursp++;
    end
    check_evt(hrsp, n, "host response count");
    check_evt(ursp, n, "uDMA response count");
    for (int i = 0; i < n; i++) begin
      l2_access(OWNER_HOST, 1'b0, base + l2_addr_t'(4 * i), '0, 4'hf, rd);
      check_l2(rd, hdata[i], "readback of host write");
      l2_access(OWNER_HOST, 1'b0, base + 32'h100 + l2_addr_t'(4 * i), '0, 4'hf, rd);
      check_l2(rd, udata[i], "readback of uDMA write");
      l2_access(OWNER_UDMA, 1'b0, base + l2_addr_t'(4 * i), '0, 4'hf, rd);
      check_l2(rd, hdata[i], "uDMA readback of host write");
    end
  endtask

  // hold > 0 keeps the response ready low for that many cycles
  task automatic cfg_access(input logic we, input cfg_offset_t offset, input cfg_data_t data,
                            input int hold, output cfg_data_t rdata);
    cfg_req_t req;
    req.offset = offset;
    req.we     = we;
    req.wdata  = data;
    @(posedge clk);
    cfg_req       <= req;
    cfg_req_valid <= 1'b1;
    if (hold > 0) cfg_rsp_ready <= 1'b0;
    @(negedge clk);
    while (!cfg_req_ready) @(negedge clk);
    @(posedge clk);
    cfg_req_valid <= 1'b0;
    @(negedge clk);
    if (!cfg_rsp_valid) report_error("configuration response missing after acceptance");
    rdata = cfg_rsp;
    for (int k = 0; k < hold; k++) begin
      @(negedge clk);
      if (!cfg_rsp_valid || cfg_req_ready) begin
        report_error("configuration response not held under back-pressure");
      end
      check_cfg(cfg_rsp, rdata, "held configuration response");
    end
    if (hold > 0) begin
      @(posedge clk);
      cfg_rsp_ready <= 1'b1;
      repeat (2) @(negedge clk);
      if (cfg_rsp_valid) report_error("configuration response stayed valid after it was taken");
    end
  endtask

  task automatic evt_toggle(input int exp_pulses, input int exp_delay);
    int pulses;
    int first;
    pulses = 0;
    first  = -1;
    @(posedge clk);
    evt_in <= ~evt_in;
    for (int j = 0; j < 8; j++) begin
      @(negedge clk);
      if (evt_pulse) begin
        pulses++;
        if (first < 0) first = j;
      end
    end
    // Pulse seen after edge j is taken at edge j+1
    check_evt(pulses, exp_pulses, "event pulse count");
    check_evt(first + 1, exp_delay, "event delay in cycles");
    check_evt(int'(evt_ack), int'(evt_in), "event acknowledge level");
  endtask

  task automatic finish_test(input int num);
    if (test_errs == 0) begin
      pass_cnt++;
      $display("test %0d done, no errors", num);
    end else begin
      fail_cnt++;
      $display("test %0d done, %0d errors", num, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic run_all();
    l2_data_t  rd;
    cfg_data_t crd;
    int        cur;
    cur = tnum[0];
    for (int i = 0; i < n_ops; i++) begin
      if (tnum[i] != cur) begin
        finish_test(cur);
        cur = tnum[i];
      end
      case (opc[i])
        "hw": begin
          l2_access(OWNER_HOST, 1'b1, acol[i], dcol[i], ecol[i][3:0], rd);
          check_l2(rd, '0, "host write acknowledge");
        end
        "hr": begin
          l2_access(OWNER_HOST, 1'b0, acol[i], '0, 4'hf, rd);
          check_l2(rd, ecol[i], "host read");
        end
        "uw": begin
          l2_access(OWNER_UDMA, 1'b1, acol[i], dcol[i], ecol[i][3:0], rd);
          check_l2(rd, '0, "uDMA write acknowledge");
        end
        "ur": begin
          l2_access(OWNER_UDMA, 1'b0, acol[i], '0, 4'hf, rd);
          check_l2(rd, ecol[i], "uDMA read");
        end
        "tie": run_tie(acol[i], int'(dcol[i]));
        "cw": begin
          cfg_access(1'b1, acol[i][7:0], dcol[i], 0, crd);
          check_cfg(crd, '0, "configuration write response");
        end
        "cr": begin
          cfg_access(1'b0, acol[i][7:0], '0, 0, crd);
          check_cfg(crd, ecol[i], "configuration read");
        end
        "cb": begin
          cfg_access(1'b0, acol[i][7:0], '0, int'(dcol[i]), crd);
          check_cfg(crd, ecol[i], "configuration read under back-pressure");
        end
        "ev": evt_toggle(int'(dcol[i]), int'(ecol[i]));
        default: report_error({"unknown operation in stimulus file: ", opc[i]});
      endcase
    end
    finish_test(cur);
  endtask

  initial begin
    bit ok;
    arst_n         = 1'b0;
    host_req       = '0;
    host_req_valid = 1'b0;
    udma_req       = '0;
    udma_req_valid = 1'b0;
    cfg_req        = '0;
    cfg_req_valid  = 1'b0;
    cfg_rsp_ready  = 1'b1;
    evt_in         = 1'b0;
    cycles         = 0;
    test_errs      = 0;
    pass_cnt       = 0;
    fail_cnt       = 0;
    load_stim(ok);
    if (!ok || n_ops == 0) begin
      $display("stimulus file host_domain_stim.txt could not be read");
      $display("tests failed");
      $finish;
    end else begin
      cycle_limit = n_ops * 20 + 200;
      repeat (10) @(posedge clk);
      arst_n <= 1'b1;
      run_all();
      $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
        $display("all tests passed");
      end else begin
        $display("tests failed");
      end
      $finish;
    end
  end

endmodule

// File: host_domain_stim.txt
# test op addr data expect (hex; for hw and uw the expect column is the byte enable)
# tie: data = writes per peer; cb: data = cycles held; ev: data = pulses, expect = delay
1 hw 00000010 11223344 f
1 hr 00000010 0 11223344
1 hw 00000010 aabbccdd 3
1 hr 00000010 0 1122ccdd
2 uw 00000040 cafef00d f
2 hr 00000040 0 cafef00d
3 tie 00000300 4 0
4 cw 0 00000080 0
4 cr 0 0 00000080
4 cw 1 ffffffff 0
4 cr 1 0 00001000
4 cr 7 0 deadf000
4 cb 0 4 00000080
5 cw 0 00000100 0
5 cw 1 000001fc 0
5 hw 00000100 01010101 f
5 hw 000001f8 02020202 f
5 hw 000001fc 03030303 f
5 hw 000000fc 04040404 f
5 hr 00000100 0 01010101
5 hr 000001fc 0 03030303
5 uw 00000140 05050505 f
5 cr 2 0 1
5 cr 3 0 2
5 cw 3 0 0
5 cr 3 0 0
6 ev 0 1 3
6 ev 0 1 3

// File: src.f
l2_map_pkg.sv
host_bus_pkg.sv
l2_rr_arbiter.sv
l2_mem.sv
llc_cfg_regs.sv
dma_evt_sync.sv
host_domain.sv
tb_host_domain.sv

// File: Makefile
# Verilator simulation of the host domain

TOP       ?= tb_host_domain
VERILATOR ?= verilator
SIM_FLAGS ?= --binary --timing
OBJ_DIR   ?= obj_dir
PASS_MSG  := all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator from src.f and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: TOP, VERILATOR, SIM_FLAGS, OBJ_DIR"

test:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f src.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
